//--- hdl/rv32i_macros.svh
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

`define RV_XLEN         32
`define RV_REG_AW       5
`define RV_RESET_PC     32'h0000_0000

`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011

`define RV_NOP          32'h0000_0013   // addi x0, x0, 0

`define RV_F3_ADD       3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SR        3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

`endif

//--- hdl/rv32i_pkg.sv
`default_nettype none
`include "rv32i_macros.svh"

package rv32i_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // control transfer resolved in ex
    typedef enum logic [3:0] {
        br_none,
        br_jal,
        br_jalr,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } br_kind_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0]    addr;
        logic                   read;
    } imem_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    inst;
    } fetch_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        alu_op_e                alu_op;
        logic [`RV_XLEN-1:0]    op1;
        logic [`RV_XLEN-1:0]    op2;
        logic [`RV_XLEN-1:0]    rs2_val;    // branch compare only
        br_kind_e               br_kind;
        logic [`RV_XLEN-1:0]    imm;
        logic [`RV_REG_AW-1:0]  rd;
        logic                   rd_we;
    } decode_t;

    typedef struct packed {
        logic                   we;
        logic [`RV_REG_AW-1:0]  addr;
        logic [`RV_XLEN-1:0]    data;
    } reg_wr_t;

endpackage

`default_nettype wire

//--- hdl/pc_fetch.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_macros.svh"

module pc_fetch (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    jtag_halt_flag_i,
    input  logic                    redirect_i,
    input  logic [`RV_XLEN-1:0]     redirect_pc_i,
    output rv32i_pkg::imem_req_t    imem_req_o,
    input  logic [`RV_XLEN-1:0]     inst_readdata_i,
    input  logic                    inst_readdata_valid_i,
    input  logic                    inst_waitrequest_i,
    output rv32i_pkg::fetch_t       fetch_o
);

    rv32i_pkg::imem_req_t req_q;
    logic [`RV_XLEN-1:0] pc_q;      // next address to fetch
    logic busy_q;                   // accepted, data not back yet
    logic drop_q;
    logic accept;
    logic rsp_ok;
    logic launch;
    logic [`RV_XLEN-1:0] pc_d;

    assign accept = req_q.read & ~inst_waitrequest_i;
    assign rsp_ok = inst_readdata_valid_i & ~drop_q;
    // bus is free after this edge
    assign launch = ~req_q.read & (~busy_q | inst_readdata_valid_i) & ~jtag_halt_flag_i;

    always_comb begin
        if (redirect_i)
            pc_d = redirect_pc_i;
        else if (rsp_ok)
            pc_d = req_q.addr + `RV_XLEN'(4);
        else
            pc_d = pc_q;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_q.read <= 1'b0;
            busy_q <= 1'b0;
            drop_q <= 1'b0;
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_d;
            if (accept)
                busy_q <= 1'b1;
            else if (inst_readdata_valid_i)
                busy_q <= 1'b0;
            // read still on the bus belongs to the old path
            if (redirect_i && (req_q.read || (busy_q && !inst_readdata_valid_i)))
                drop_q <= 1'b1;
            else if (inst_readdata_valid_i)
                drop_q <= 1'b0;
            if (accept) begin
                req_q.read <= 1'b0;
            end else if (launch) begin
                req_q.read <= 1'b1;
                req_q.addr <= pc_d;     // held until accepted
            end
        end
    end

    assign imem_req_o = req_q;

    always_comb begin
        fetch_o.valid = rsp_ok;
        fetch_o.pc = req_q.addr;
        fetch_o.inst = rsp_ok ? inst_readdata_i : `RV_NOP;
    end

endmodule

`default_nettype wire

//--- hdl/pipe_stage.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        flush_i,
    input  payload_t    d_i,
    output payload_t    q_o
);

    payload_t q_r;

    // no stall path, the stage loads every cycle
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            q_r <= '0;      // valid bit low
        end else begin
            q_r <= d_i;
        end
    end

    assign q_o = q_r;

endmodule

`default_nettype wire

//--- hdl/id.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_macros.svh"

module id (
    input  rv32i_pkg::fetch_t       fetch_i,
    output logic [`RV_REG_AW-1:0]   rs1_addr_o,
    output logic [`RV_REG_AW-1:0]   rs2_addr_o,
    input  logic [`RV_XLEN-1:0]     rs1_data_i,
    input  logic [`RV_XLEN-1:0]     rs2_data_i,
    output rv32i_pkg::decode_t      decode_o
);

    logic [31:0] inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic known;

    function automatic rv32i_pkg::alu_op_e alu_sel(
        input logic [2:0] f3,
        input logic alt_sub,
        input logic alt_sra
    );
        rv32i_pkg::alu_op_e op;
        case (f3)
            `RV_F3_ADD:  op = alt_sub ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
            `RV_F3_SLL:  op = rv32i_pkg::alu_sll;
            `RV_F3_SLT:  op = rv32i_pkg::alu_slt;
            `RV_F3_SLTU: op = rv32i_pkg::alu_sltu;
            `RV_F3_XOR:  op = rv32i_pkg::alu_xor;
            `RV_F3_SR:   op = alt_sra ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            `RV_F3_OR:   op = rv32i_pkg::alu_or;
            default:     op = rv32i_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign inst = fetch_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd = inst[11:7];
    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        known = 1'b1;
        decode_o = '0;
        decode_o.pc = fetch_i.pc;
        decode_o.rd = rd;
        decode_o.op1 = rs1_data_i;
        decode_o.op2 = rs2_data_i;
        decode_o.rs2_val = rs2_data_i;
        decode_o.alu_op = rv32i_pkg::alu_add;
        decode_o.br_kind = rv32i_pkg::br_none;
        decode_o.imm = imm_i;
        case (opcode)
            `RV_OP_LUI: begin
                decode_o.op1 = '0;
                decode_o.op2 = imm_u;
                decode_o.alu_op = rv32i_pkg::alu_pass_b;
            end
            `RV_OP_AUIPC: begin
                decode_o.op1 = fetch_i.pc;
                decode_o.op2 = imm_u;
            end
            `RV_OP_JAL: begin
                decode_o.op1 = fetch_i.pc;
                decode_o.op2 = `RV_XLEN'(4);    // link = pc + 4
                decode_o.br_kind = rv32i_pkg::br_jal;
                decode_o.imm = imm_j;
            end
            `RV_OP_JALR: begin
                decode_o.op2 = `RV_XLEN'(4);    // op1 stays rs1 for the target
                decode_o.br_kind = rv32i_pkg::br_jalr;
            end
            `RV_OP_BRANCH: begin
                decode_o.imm = imm_b;
                case (funct3)
                    3'b000:  decode_o.br_kind = rv32i_pkg::br_eq;
                    3'b001:  decode_o.br_kind = rv32i_pkg::br_ne;
                    3'b100:  decode_o.br_kind = rv32i_pkg::br_lt;
                    3'b101:  decode_o.br_kind = rv32i_pkg::br_ge;
                    3'b110:  decode_o.br_kind = rv32i_pkg::br_ltu;
                    3'b111:  decode_o.br_kind = rv32i_pkg::br_geu;
                    default: known = 1'b0;
                endcase
            end
            `RV_OP_IMM: begin
                decode_o.op2 = imm_i;
                decode_o.alu_op = alu_sel(funct3, 1'b0, funct7[5]);
            end
            `RV_OP_REG: decode_o.alu_op = alu_sel(funct3, funct7[5], funct7[5]);
            default: known = 1'b0;
        endcase
        decode_o.valid = fetch_i.valid & known;
        decode_o.rd_we = known && opcode != `RV_OP_BRANCH && rd != '0;
    end

endmodule

`default_nettype wire

//--- hdl/regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_macros.svh"

module regs (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  rv32i_pkg::reg_wr_t      wr_i,
    input  logic [`RV_REG_AW-1:0]   rs1_addr_i,
    input  logic [`RV_REG_AW-1:0]   rs2_addr_i,
    output logic [`RV_XLEN-1:0]     rs1_data_o,
    output logic [`RV_XLEN-1:0]     rs2_data_o,
    input  logic [`RV_REG_AW-1:0]   dbg_reg_addr_i,
    output logic [`RV_XLEN-1:0]     dbg_reg_data_o
);

    logic [`RV_XLEN-1:0] rf_q [1:31];   // x0 has no storage

    function automatic logic [`RV_XLEN-1:0] read_port(
        input logic [`RV_REG_AW-1:0] addr,
        input logic [`RV_XLEN-1:0] stored,
        input rv32i_pkg::reg_wr_t wr
    );
        if (addr == '0)
            return '0;
        if (wr.we && wr.addr == addr)
            return wr.data;     // ex writing this cycle
        return stored;
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++)
                rf_q[i] <= '0;
        end else if (wr_i.we && wr_i.addr != '0) begin
            rf_q[wr_i.addr] <= wr_i.data;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i, rf_q[rs1_addr_i], wr_i);
        rs2_data_o = read_port(rs2_addr_i, rf_q[rs2_addr_i], wr_i);
        dbg_reg_data_o = read_port(dbg_reg_addr_i, rf_q[dbg_reg_addr_i], wr_i);
    end

endmodule

`default_nettype wire

//--- hdl/ex.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_macros.svh"

module ex (
    input  rv32i_pkg::decode_t      decode_i,
    output rv32i_pkg::reg_wr_t      wr_o,
    output logic                    redirect_o,
    output logic [`RV_XLEN-1:0]     redirect_pc_o
);

    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] target;
    logic [4:0] shamt;
    logic taken;
    logic is_jalr;

    assign is_jalr = decode_i.br_kind == rv32i_pkg::br_jalr;
    // jalr carries rs1 in op1, link still comes from the pc
    assign alu_a = is_jalr ? decode_i.pc : decode_i.op1;
    assign alu_b = decode_i.op2;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (decode_i.alu_op)
            rv32i_pkg::alu_sub:    result = alu_a - alu_b;
            rv32i_pkg::alu_sll:    result = alu_a << shamt;
            rv32i_pkg::alu_slt: begin
                result = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            end
            rv32i_pkg::alu_sltu:   result = {{(`RV_XLEN-1){1'b0}}, alu_a < alu_b};
            rv32i_pkg::alu_xor:    result = alu_a ^ alu_b;
            rv32i_pkg::alu_srl:    result = alu_a >> shamt;
            rv32i_pkg::alu_sra:    result = $unsigned($signed(alu_a) >>> shamt);
            rv32i_pkg::alu_or:     result = alu_a | alu_b;
            rv32i_pkg::alu_and:    result = alu_a & alu_b;
            rv32i_pkg::alu_pass_b: result = alu_b;
            default:               result = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (decode_i.br_kind)
            rv32i_pkg::br_jal,
            rv32i_pkg::br_jalr: taken = 1'b1;
            rv32i_pkg::br_eq:   taken = decode_i.op1 == decode_i.rs2_val;
            rv32i_pkg::br_ne:   taken = decode_i.op1 != decode_i.rs2_val;
            rv32i_pkg::br_lt:   taken = $signed(decode_i.op1) < $signed(decode_i.rs2_val);
            rv32i_pkg::br_ge:   taken = $signed(decode_i.op1) >= $signed(decode_i.rs2_val);
            rv32i_pkg::br_ltu:  taken = decode_i.op1 < decode_i.rs2_val;
            rv32i_pkg::br_geu:  taken = decode_i.op1 >= decode_i.rs2_val;
            default:            taken = 1'b0;
        endcase
    end

    always_comb begin
        if (is_jalr) begin
            target = decode_i.op1 + decode_i.imm;
            target[0] = 1'b0;
        end else begin
            target = decode_i.pc + decode_i.imm;
        end
    end

    assign redirect_o = decode_i.valid & taken;     // flushes both stages
    assign redirect_pc_o = target;

    always_comb begin
        wr_o.we = decode_i.valid & decode_i.rd_we;
        wr_o.addr = decode_i.rd;
        wr_o.data = result;
    end

endmodule

`default_nettype wire

//--- hdl/rv32i.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_macros.svh"

module rv32i (
    input  logic                    clk_i,
    input  logic                    reset_i,
    output rv32i_pkg::imem_req_t    imem_req_o,
    input  logic [`RV_XLEN-1:0]     inst_readdata_i,
    input  logic                    inst_readdata_valid_i,
    input  logic                    inst_waitrequest_i,
    input  logic                    jtag_halt_flag_i,
    input  logic [`RV_REG_AW-1:0]   dbg_reg_addr_i,
    output logic [`RV_XLEN-1:0]     dbg_reg_data_o
);

    rv32i_pkg::fetch_t fetch_d;
    rv32i_pkg::fetch_t fetch_q;
    rv32i_pkg::decode_t decode_d;
    rv32i_pkg::decode_t decode_q;
    rv32i_pkg::reg_wr_t ex_wr;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic redirect;
    logic [`RV_XLEN-1:0] redirect_pc;

    pc_fetch u_pc_fetch (
        .clk_i                  (clk_i),
        .reset_i                (reset_i),
        .jtag_halt_flag_i       (jtag_halt_flag_i),
        .redirect_i             (redirect),
        .redirect_pc_i          (redirect_pc),
        .imem_req_o             (imem_req_o),
        .inst_readdata_i        (inst_readdata_i),
        .inst_readdata_valid_i  (inst_readdata_valid_i),
        .inst_waitrequest_i     (inst_waitrequest_i),
        .fetch_o                (fetch_d)
    );

    pipe_stage #(.payload_t(rv32i_pkg::fetch_t)) u_if_id (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (redirect),
        .d_i        (fetch_d),
        .q_o        (fetch_q)
    );

    id u_id (
        .fetch_i    (fetch_q),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .decode_o   (decode_d)
    );

    regs u_regs (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .wr_i           (ex_wr),
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .dbg_reg_addr_i (dbg_reg_addr_i),
        .dbg_reg_data_o (dbg_reg_data_o)
    );

    pipe_stage #(.payload_t(rv32i_pkg::decode_t)) u_id_ex (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (redirect),
        .d_i        (decode_d),
        .q_o        (decode_q)
    );

    ex u_ex (
        .decode_i       (decode_q),
        .wr_o           (ex_wr),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc)
    );

endmodule

`default_nettype wire

//--- tests/rv32i_chk.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_chk (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  rv32i_pkg::imem_req_t    imem_req_i,
    input  logic                    inst_waitrequest_i,
    input  logic                    inst_readdata_valid_i
);

    logic outstanding_q;    // accepted read without its data yet

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            outstanding_q <= 1'b0;
        end else if (imem_req_i.read && !inst_waitrequest_i) begin
            outstanding_q <= 1'b1;
        end else if (inst_readdata_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    read_low_in_reset: assert property (@(posedge clk_i) reset_i |=> !imem_req_i.read)
        else $error("instruction read raised during reset");

    hold_while_waiting: assert property (@(posedge clk_i) disable iff (reset_i)
        imem_req_i.read && inst_waitrequest_i |=> imem_req_i.read && $stable(imem_req_i.addr))
        else $error("instruction request changed while waitrequest was high");

    one_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
        outstanding_q && !inst_readdata_valid_i |-> !imem_req_i.read)
        else $error("new instruction read raised while one is outstanding");

endmodule

bind rv32i rv32i_chk chk0 (
    .clk_i                  (clk_i),
    .reset_i                (reset_i),
    .imem_req_i             (imem_req_o),
    .inst_waitrequest_i     (inst_waitrequest_i),
    .inst_readdata_valid_i  (inst_readdata_valid_i)
);

`default_nettype wire

//--- tests/rv32i_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_macros.svh"

module rv32i_tb;

    localparam int MEM_WORDS = 256;
    localparam int MAX_STEPS = 1024;
    localparam logic [31:0] SEED = 32'he80b5619;

    logic clk_i = 1'b0;
    logic reset_i;
    rv32i_pkg::imem_req_t imem_req;
    logic [`RV_XLEN-1:0] inst_readdata;
    logic inst_readdata_valid;
    logic inst_waitrequest;
    logic jtag_halt_flag;
    logic [`RV_REG_AW-1:0] dbg_reg_addr;
    logic [`RV_XLEN-1:0] dbg_reg_data;

    logic [31:0] gen_seed;
    logic [31:0] bus_seed;
    logic [31:0] prog [MEM_WORDS];
    int prog_len;
    logic [31:0] end_pc;        // the jump to itself
    logic [4:0] last_rd;
    logic [31:0] model_x [32];
    logic [31:0] exp_pc [MAX_STEPS];
    logic exp_taken [MAX_STEPS];
    int n_exp;
    int exp_idx = 0;
    logic skipping = 1'b0;
    logic [31:0] skip_base;
    int skip_cnt;
    logic reached_end = 1'b0;
    logic bus_idle_after_halt = 1'b0;
    logic rsp_pending;
    int rsp_delay;
    logic [31:0] rsp_addr;
    logic [1:0] wait_roll;

    rv32i dut0 (
        .clk_i                  (clk_i),
        .reset_i                (reset_i),
        .imem_req_o             (imem_req),
        .inst_readdata_i        (inst_readdata),
        .inst_readdata_valid_i  (inst_readdata_valid),
        .inst_waitrequest_i     (inst_waitrequest),
        .jtag_halt_flag_i       (jtag_halt_flag),
        .dbg_reg_addr_i         (dbg_reg_addr),
        .dbg_reg_data_o         (dbg_reg_data)
    );

    always #50 clk_i = ~clk_i;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(inout logic [31:0] st, input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = st[31] ^ st[21] ^ st[1] ^ st[0];
            st = {st[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    // addi x0 with an immediate folded from the address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (addr < 32'(prog_len * 4))
            return prog[addr[9:2]];
        return {addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]}, 13'd0, `RV_OP_IMM};
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            `RV_F3_ADD:  return alt ? a - b : a + b;
            `RV_F3_SLL:  return a << b[4:0];
            `RV_F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
            `RV_F3_SLTU: return {31'd0, a < b};
            `RV_F3_XOR:  return a ^ b;
            `RV_F3_SR: begin
                if (alt)
                    return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            `RV_F3_OR:   return a | b;
            default:     return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [`RV_XLEN-1:0] got,
                              input logic [`RV_XLEN-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("Error %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_addr(input rv32i_pkg::imem_req_t got, input rv32i_pkg::imem_req_t exp);
        if (got.addr !== exp.addr)
            stop_run($sformatf("Error %0t: fetch address %h, expected %h",
                               $time, got.addr, exp.addr));
    endtask

    task automatic put(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic put_alu();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [11:0] imm;
        logic alt;
        logic [1:0] kind;
        rd = 5'(lfsr_bits(gen_seed, 5));
        rs1 = 1'(lfsr_bits(gen_seed, 1)) ? last_rd : 5'(lfsr_bits(gen_seed, 5));  // back to back
        rs2 = 5'(lfsr_bits(gen_seed, 5));
        f3 = 3'(lfsr_bits(gen_seed, 3));
        alt = 1'(lfsr_bits(gen_seed, 1));
        kind = 2'(lfsr_bits(gen_seed, 2));
        imm = 12'(lfsr_bits(gen_seed, 12));
        if (kind == 2'd3) begin
            put({imm, 8'(lfsr_bits(gen_seed, 8)), rd, alt ? `RV_OP_LUI : `RV_OP_AUIPC});
        end else if (kind[0]) begin
            put(enc_r((f3 == `RV_F3_ADD || f3 == `RV_F3_SR) && alt ? 7'h20 : 7'h00,
                      rs2, rs1, f3, rd));
        end else begin
            if (f3 == `RV_F3_SLL)
                imm = {7'h00, rs2};
            else if (f3 == `RV_F3_SR)
                imm = {alt ? 7'h20 : 7'h00, rs2};
            put(enc_i(imm, rs1, f3, rd, `RV_OP_IMM));
        end
        last_rd = rd;
    endtask

    // forward transfers only with targets at least three words ahead
    task automatic build_program();
        int seg;
        int off_w;
        int k;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rx;
        logic [11:0] jimm;
        logic [31:0] tgt;
        prog_len = 0;
        last_rd = '0;
        while (prog_len < 150) begin
            seg = int'(lfsr_bits(gen_seed, 3));
            off_w = 3 + int'(lfsr_bits(gen_seed, 2));
            rd = 5'(lfsr_bits(gen_seed, 5));
            rs1 = 5'(lfsr_bits(gen_seed, 5));
            rs2 = 1'(lfsr_bits(gen_seed, 1)) ? rs1 : 5'(lfsr_bits(gen_seed, 5));
            case (seg)
                4: begin
                    k = int'(lfsr_bits(gen_seed, 3)) % 6;
                    put(enc_b(13'(off_w * 4), rs2, rs1, k < 2 ? 3'(k) : 3'(k + 2)));
                    repeat (off_w - 1) put_alu();
                end
                5: begin
                    put(enc_j(21'(off_w * 4), rd));
                    repeat (off_w - 1) put_alu();
                end
                6: begin
                    rx = (rs1 == '0) ? 5'd1 : rs1;
                    jimm = 12'(4 * int'(lfsr_bits(gen_seed, 2)) - 4);
                    tgt = 32'((prog_len + 1 + off_w) * 4) - {{20{jimm[11]}}, jimm}
                        + lfsr_bits(gen_seed, 1);   // bit 0 gets cleared
                    put(enc_i(tgt[11:0], 5'd0, `RV_F3_ADD, rx, `RV_OP_IMM));
                    put(enc_i(jimm, rx, 3'b000, rd, `RV_OP_JALR));
                    repeat (off_w - 1) put_alu();
                end
                default: put_alu();
            endcase
        end
        end_pc = 32'(prog_len * 4);
        put(enc_j(21'd0, 5'(lfsr_bits(gen_seed, 5))));
    endtask

    // reference model stepping one instruction at a time in program order
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] nxt;
        logic [2:0] f3;
        logic taken;
        logic wr;
        for (int r = 0; r < 32; r++)
            model_x[r] = '0;
        pc = `RV_RESET_PC;
        n_exp = 0;
        while (n_exp < MAX_STEPS) begin
            inst = prog[pc[9:2]];
            f3 = inst[14:12];
            a = model_x[inst[19:15]];
            b = model_x[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            nxt = pc + 32'd4;
            taken = 1'b0;
            wr = 1'b1;
            res = '0;
            case (inst[6:0])
                `RV_OP_LUI:   res = {inst[31:12], 12'h0};
                `RV_OP_AUIPC: res = pc + {inst[31:12], 12'h0};
                `RV_OP_JAL: begin
                    res = pc + 32'd4;
                    taken = 1'b1;
                    nxt = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                `RV_OP_JALR: begin
                    res = pc + 32'd4;
                    taken = 1'b1;
                    nxt = (a + imm_i) & ~32'h1;
                end
                `RV_OP_BRANCH: begin
                    wr = 1'b0;
                    taken = branch_taken(f3, a, b);
                    if (taken)
                        nxt = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
                `RV_OP_IMM: res = alu(f3, inst[30] && f3 == `RV_F3_SR, a, imm_i);
                `RV_OP_REG: res = alu(f3, inst[30], a, b);
                default:    wr = 1'b0;
            endcase
            exp_pc[n_exp] = pc;
            exp_taken[n_exp] = taken;
            n_exp++;
            if (wr && inst[11:7] != 5'd0)
                model_x[inst[11:7]] = res;
            if (pc == end_pc)
                break;
            pc = nxt;
        end
    endtask

    // one wrong-path fetch can follow a taken transfer
    task automatic track_fetch(input rv32i_pkg::imem_req_t req);
        rv32i_pkg::imem_req_t exp_req;
        exp_req.read = 1'b1;
        exp_req.addr = exp_pc[exp_idx];
        if (req.addr == exp_req.addr) begin
            skipping = exp_taken[exp_idx];
            skip_base = req.addr;
            skip_cnt = 0;
            if (req.addr == end_pc)
                reached_end <= 1'b1;
            else
                exp_idx++;
        end else if (skipping && skip_cnt < 1
                     && req.addr == skip_base + 32'(4 * (skip_cnt + 1))) begin
            skip_cnt++;
        end else begin
            check_addr(req, exp_req);
        end
    endtask

    // instruction memory with random wait and response delay
    always @(posedge clk_i) begin
        if (reset_i) begin
            inst_readdata_valid <= 1'b0;
            inst_waitrequest <= 1'b0;
            rsp_pending <= 1'b0;
        end else begin
            wait_roll = 2'(lfsr_bits(bus_seed, 2));
            inst_waitrequest <= wait_roll == 2'd0;
            inst_readdata_valid <= 1'b0;
            if (rsp_pending) begin
                if (rsp_delay == 1) begin
                    inst_readdata_valid <= 1'b1;
                    inst_readdata <= mem_word(rsp_addr);
                    rsp_pending <= 1'b0;
                end else begin
                    rsp_delay <= rsp_delay - 1;
                end
            end
            if (imem_req.read && !inst_waitrequest) begin
                if (rsp_pending)
                    stop_run("a second read was accepted while one was outstanding");
                if (bus_idle_after_halt)
                    stop_run("a read was accepted after halt had drained the bus");
                rsp_pending <= 1'b1;
                rsp_delay <= 1 + int'(lfsr_bits(bus_seed, 2));
                rsp_addr <= imem_req.addr;
                track_fetch(imem_req);
            end
            if (jtag_halt_flag && !imem_req.read && !rsp_pending)
                bus_idle_after_halt <= 1'b1;
        end
    end

    initial begin
        int cycles;
        reset_i = 1'b1;
        jtag_halt_flag = 1'b0;
        dbg_reg_addr = '0;
        inst_readdata = '0;
        inst_readdata_valid = 1'b0;
        inst_waitrequest = 1'b0;
        gen_seed = SEED;
        bus_seed = SEED;
        void'(lfsr_bits(bus_seed, 17));
        build_program();
        run_model();
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;

        cycles = 0;
        while (!reached_end) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > 50000)
                stop_run("timeout: the final jump was never fetched");
        end
        jtag_halt_flag <= 1'b1;

        cycles = 0;
        while (!bus_idle_after_halt) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > 200)
                stop_run("timeout: the instruction bus did not go idle under halt");
        end
        repeat (4) @(posedge clk_i);    // two stages plus the write

        for (int r = 0; r < 32; r++) begin
            dbg_reg_addr <= 5'(r);
            @(posedge clk_i);
            check_word($sformatf("x%0d", r), dbg_reg_data, model_x[r]);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv32i.f
+incdir+hdl
hdl/rv32i_pkg.sv
hdl/pc_fetch.sv
hdl/pipe_stage.sv
hdl/id.sv
hdl/regs.sv
hdl/ex.sv
hdl/rv32i.sv
tests/rv32i_chk.sv
tests/rv32i_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, then look for the pass line in the simulation output
verilator --binary --assert -Wno-fatal -f rv32i.f --top-module rv32i_tb -o rv32i_sim \
    && ./obj_dir/rv32i_sim | grep -q "all tests passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
